// File: source/rxrPkg.sv
`default_nettype none

package rxrPkg;

    // Beat geometry
    localparam int dataWidthC = 128;
    localparam int dwPerBeatC = 4;

    typedef logic [$clog2(dwPerBeatC)-1:0] dwOffsetT;
    typedef logic [dwPerBeatC-1:0]         wordEnableT;
    typedef logic [7:0]                    barDecodeT;
    typedef logic [63:0]                   addrT;

    // Type field of MRd and MWr, format bits decide the rest
    localparam logic [4:0] memTypeC = 5'b00000;

    // Bit positions inside the 3-bit format field
    localparam int fmt4DwBitC     = 0;
    localparam int fmtPayloadBitC = 1;

    // First payload DW inside the beat that carries it
    localparam dwOffsetT hdr3DwDataOffC = 2'd3;
    localparam dwOffsetT hdr4DwDataOffC = 2'd0;

    typedef enum logic [1:0] {
        rxrMemRd = 2'd0,
        rxrMemWr = 2'd1
    } rxrTypeT;

    // DW0, common to every request
    typedef struct packed {
        logic [2:0] fmt;
        logic [4:0] tlpType;
        logic       rsvd0;
        logic [2:0] tc;
        logic [3:0] rsvd1;
        logic       td;
        logic       ep;
        logic [1:0] attr;
        logic [1:0] at;
        logic [9:0] length;
    } hdrDw0T;

    // DW1, requester side of a memory request
    typedef struct packed {
        logic [15:0] requesterId;
        logic [7:0]  tag;
        logic [3:0]  lastBe;
        logic [3:0]  firstBe;
    } hdrDw1T;

    // DW0 sits in the low bits, so the views list DW3 first
    typedef struct packed {
        logic [31:0] rsvd;
        logic [31:0] addr;
        hdrDw1T      dw1;
        hdrDw0T      dw0;
    } hdr3DwT;

    typedef struct packed {
        logic [31:0] addrLo;
        logic [31:0] addrHi;
        hdrDw1T      dw1;
        hdrDw0T      dw0;
    } hdr4DwT;

    typedef union packed {
        hdr3DwT h3;
        hdr4DwT h4;
    } reqHdrU;

endpackage

`default_nettype wire

// File: source/rxrBeatIf.sv
`timescale 1ns/1ps
`default_nettype none

// One registered beat plus the header of its packet
interface rxrBeatIf
    import rxrPkg::*;
();

    logic [dataWidthC-1:0] data;
    logic                  valid;
    logic                  startFlag;
    logic                  endFlag;
    dwOffsetT              endOffset;
    barDecodeT             barDecode;
    reqHdrU                hdr;

    modport src (
        output data, valid, startFlag, endFlag, endOffset, barDecode, hdr
    );

    modport dst (
        input data, valid, startFlag, endFlag, endOffset, barDecode, hdr
    );

endinterface

`default_nettype wire

// File: source/rxrMetaIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded request fields and beat qualifiers for the output side
interface rxrMetaIf
    import rxrPkg::*;
();

    logic        valid;
    wordEnableT  wordEnable;
    logic        startFlag;
    dwOffsetT    startOffset;
    logic        endFlag;
    dwOffsetT    endOffset;
    logic [3:0]  fdwbe;
    logic [3:0]  ldwbe;
    logic [2:0]  tc;
    logic [1:0]  attr;
    logic [7:0]  tag;
    rxrTypeT     reqType;
    addrT        addr;
    barDecodeT   barDecoded;
    logic [15:0] requesterId;
    logic [9:0]  length;
    logic        ep;

    modport src (
        output valid, wordEnable, startFlag, startOffset, endFlag, endOffset,
        output fdwbe, ldwbe, tc, attr, tag, reqType, addr, barDecoded,
        output requesterId, length, ep
    );

    modport dst (
        input valid, wordEnable, startFlag, startOffset, endFlag, endOffset,
        input fdwbe, ldwbe, tc, attr, tag, reqType, addr, barDecoded,
        input requesterId, length, ep
    );

endinterface

`default_nettype wire

// File: source/rxrHdrCapture.sv
`timescale 1ns/1ps
`default_nettype none

module rxrHdrCapture
    import rxrPkg::*;
(
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic [dataWidthC-1:0] rxTlp,
    input  logic                  rxTlpValid,
    input  logic                  rxTlpStartFlag,
    input  logic                  rxTlpEndFlag,
    input  dwOffsetT              rxTlpEndOffset,
    input  barDecodeT             rxTlpBarDecode,
    rxrBeatIf.src                 beat
);

    logic hdrLoad;

    // Every packet starts at DW0, so a start beat holds the whole header
    assign hdrLoad = rxTlpValid & rxTlpStartFlag;

    // Qualifiers of the input stage
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            beat.valid     <= 1'b0;
            beat.startFlag <= 1'b0;
            beat.endFlag   <= 1'b0;
        end else begin
            beat.valid     <= rxTlpValid;
            beat.startFlag <= rxTlpStartFlag;
            beat.endFlag   <= rxTlpEndFlag;
        end
    end

    // Beat payload, taken every cycle
    always_ff @(posedge CLK) begin
        beat.data      <= rxTlp;
        beat.endOffset <= rxTlpEndOffset;
    end

    // Header and BAR hit stay with the packet until the next start beat.
    // Loading on the same edge as the data keeps the start beat and its
    // header aligned on the stage output.
    always_ff @(posedge CLK) begin
        if (hdrLoad) begin
            beat.hdr       <= reqHdrU'(rxTlp);
            beat.barDecode <= rxTlpBarDecode;
        end
    end

endmodule

`default_nettype wire

// File: source/rxrReqDecode.sv
`timescale 1ns/1ps
`default_nettype none

module rxrReqDecode
    import rxrPkg::*;
(
    input  logic  CLK,
    input  logic  arstN,
    rxrBeatIf.dst beatIn,
    rxrBeatIf.src beatOut,
    rxrMetaIf.src meta
);

    logic       isMem;
    logic       is4Dw;
    logic       hasPayload;
    logic       sop;
    logic       contBeat;
    logic       hdrStart;
    logic       inPkt;
    logic       pend4Dw;
    logic       nextValid;
    logic       nextStart;
    dwOffsetT   startOff;
    wordEnableT startMask;
    wordEnableT endMask;
    wordEnableT nextEnable;
    addrT       nextAddr;

    assign isMem      = beatIn.hdr.h3.dw0.tlpType == memTypeC;
    assign is4Dw      = beatIn.hdr.h3.dw0.fmt[fmt4DwBitC];
    assign hasPayload = beatIn.hdr.h3.dw0.fmt[fmtPayloadBitC];
    assign sop        = beatIn.valid & beatIn.startFlag;
    assign contBeat   = beatIn.valid & ~beatIn.startFlag;

    // A 4DW write has no data on its header beat
    assign hdrStart  = sop & isMem & ~(is4Dw & hasPayload);
    assign nextValid = hdrStart | (contBeat & inPkt);
    assign nextStart = hdrStart | (contBeat & pend4Dw);

    assign startOff  = is4Dw ? hdr4DwDataOffC : hdr3DwDataOffC;
    assign startMask = nextStart ? wordEnableT'('1) << startOff : '1;
    assign endMask   = beatIn.endFlag ? ~(wordEnableT'('1) << (beatIn.endOffset + 3'd1)) : '1;
    assign nextEnable = startMask & endMask & {dwPerBeatC{nextValid & hasPayload}};

    assign nextAddr = is4Dw ? {beatIn.hdr.h4.addrHi, beatIn.hdr.h4.addrLo}
                            : addrT'(beatIn.hdr.h3.addr);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            inPkt             <= 1'b0;
            pend4Dw           <= 1'b0;
            meta.valid        <= 1'b0;
            meta.startFlag    <= 1'b0;
            meta.endFlag      <= 1'b0;
            meta.wordEnable   <= '0;
            beatOut.valid     <= 1'b0;
            beatOut.startFlag <= 1'b0;
            beatOut.endFlag   <= 1'b0;
        end else begin
            // Packet tracking, only a valid beat moves it
            if (sop) begin
                inPkt   <= isMem & ~beatIn.endFlag;
                pend4Dw <= isMem & is4Dw & hasPayload;
            end else if (contBeat) begin
                inPkt   <= inPkt & ~beatIn.endFlag;
                pend4Dw <= 1'b0;
            end
            meta.valid        <= nextValid;
            meta.startFlag    <= nextStart;
            meta.endFlag      <= beatIn.endFlag;
            meta.wordEnable   <= nextEnable;
            beatOut.valid     <= nextValid;
            beatOut.startFlag <= nextStart;
            beatOut.endFlag   <= beatIn.endFlag & nextValid;
        end
    end

    // Data and header fields
    always_ff @(posedge CLK) begin
        meta.startOffset  <= startOff;
        meta.endOffset    <= beatIn.endOffset;
        meta.fdwbe        <= beatIn.hdr.h3.dw1.firstBe;
        meta.ldwbe        <= beatIn.hdr.h3.dw1.lastBe;
        meta.tc           <= beatIn.hdr.h3.dw0.tc;
        meta.attr         <= beatIn.hdr.h3.dw0.attr;
        meta.tag          <= beatIn.hdr.h3.dw1.tag;
        meta.reqType      <= hasPayload ? rxrMemWr : rxrMemRd;
        meta.addr         <= nextAddr;
        meta.barDecoded   <= beatIn.barDecode;
        meta.requesterId  <= beatIn.hdr.h3.dw1.requesterId;
        meta.length       <= beatIn.hdr.h3.dw0.length;
        meta.ep           <= beatIn.hdr.h3.dw0.ep;
        beatOut.data      <= beatIn.data;
        beatOut.endOffset <= beatIn.endOffset;
        beatOut.barDecode <= beatIn.barDecode;
        beatOut.hdr       <= beatIn.hdr;
    end

endmodule

`default_nettype wire

// File: source/rxrOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

module rxrOutputStage
    import rxrPkg::*;
(
    input  logic                  CLK,
    input  logic                  arstN,
    rxrBeatIf.dst                 beat,
    rxrMetaIf.dst                 meta,
    output logic [dataWidthC-1:0] rxrData,
    output logic                  rxrDataValid,
    output wordEnableT            rxrDataWordEnable,
    output logic                  rxrDataStartFlag,
    output dwOffsetT              rxrDataStartOffset,
    output logic                  rxrDataEndFlag,
    output dwOffsetT              rxrDataEndOffset,
    output logic [3:0]            rxrMetaFdwbe,
    output logic [3:0]            rxrMetaLdwbe,
    output logic [2:0]            rxrMetaTc,
    output logic [1:0]            rxrMetaAttr,
    output logic [7:0]            rxrMetaTag,
    output rxrTypeT               rxrMetaType,
    output addrT                  rxrMetaAddr,
    output barDecodeT             rxrMetaBarDecoded,
    output logic [15:0]           rxrMetaRequesterId,
    output logic [9:0]            rxrMetaLength,
    output logic                  rxrMetaEp
);

    // Flags of dropped beats never reach the ports
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rxrDataValid      <= 1'b0;
            rxrDataStartFlag  <= 1'b0;
            rxrDataEndFlag    <= 1'b0;
            rxrDataWordEnable <= '0;
        end else begin
            rxrDataValid      <= meta.valid;
            rxrDataStartFlag  <= meta.startFlag & meta.valid;
            rxrDataEndFlag    <= meta.endFlag & meta.valid;
            rxrDataWordEnable <= meta.wordEnable;
        end
    end

    always_ff @(posedge CLK) begin
        rxrData            <= beat.data;
        rxrDataStartOffset <= meta.startOffset;
        rxrDataEndOffset   <= meta.endOffset;
        rxrMetaFdwbe       <= meta.fdwbe;
        rxrMetaLdwbe       <= meta.ldwbe;
        rxrMetaTc          <= meta.tc;
        rxrMetaAttr        <= meta.attr;
        rxrMetaTag         <= meta.tag;
        rxrMetaType        <= meta.reqType;
        rxrMetaAddr        <= meta.addr;
        rxrMetaBarDecoded  <= meta.barDecoded;
        rxrMetaRequesterId <= meta.requesterId;
        rxrMetaLength      <= meta.length;
        rxrMetaEp          <= meta.ep;
    end

endmodule

`default_nettype wire

// File: source/rxrEngine.sv
`timescale 1ns/1ps
`default_nettype none

module rxrEngine
    import rxrPkg::*;
(
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic [dataWidthC-1:0] rxTlp,
    input  logic                  rxTlpValid,
    input  logic                  rxTlpStartFlag,
    input  logic                  rxTlpEndFlag,
    input  dwOffsetT              rxTlpEndOffset,
    input  barDecodeT             rxTlpBarDecode,
    output logic [dataWidthC-1:0] rxrData,
    output logic                  rxrDataValid,
    output wordEnableT            rxrDataWordEnable,
    output logic                  rxrDataStartFlag,
    output dwOffsetT              rxrDataStartOffset,
    output logic                  rxrDataEndFlag,
    output dwOffsetT              rxrDataEndOffset,
    output logic [3:0]            rxrMetaFdwbe,
    output logic [3:0]            rxrMetaLdwbe,
    output logic [2:0]            rxrMetaTc,
    output logic [1:0]            rxrMetaAttr,
    output logic [7:0]            rxrMetaTag,
    output rxrTypeT               rxrMetaType,
    output addrT                  rxrMetaAddr,
    output barDecodeT             rxrMetaBarDecoded,
    output logic [15:0]           rxrMetaRequesterId,
    output logic [9:0]            rxrMetaLength,
    output logic                  rxrMetaEp
);

    // Input, computation and output stages, one cycle each
    rxrBeatIf beatS1();
    rxrBeatIf beatS2();
    rxrMetaIf metaS2();

    rxrHdrCapture uHdrCapture (
        .CLK            (CLK),
        .arstN          (arstN),
        .rxTlp          (rxTlp),
        .rxTlpValid     (rxTlpValid),
        .rxTlpStartFlag (rxTlpStartFlag),
        .rxTlpEndFlag   (rxTlpEndFlag),
        .rxTlpEndOffset (rxTlpEndOffset),
        .rxTlpBarDecode (rxTlpBarDecode),
        .beat           (beatS1.src)
    );

    rxrReqDecode uReqDecode (
        .CLK     (CLK),
        .arstN   (arstN),
        .beatIn  (beatS1.dst),
        .beatOut (beatS2.src),
        .meta    (metaS2.src)
    );

    rxrOutputStage uOutputStage (
        .CLK                (CLK),
        .arstN              (arstN),
        .beat               (beatS2.dst),
        .meta               (metaS2.dst),
        .rxrData            (rxrData),
        .rxrDataValid       (rxrDataValid),
        .rxrDataWordEnable  (rxrDataWordEnable),
        .rxrDataStartFlag   (rxrDataStartFlag),
        .rxrDataStartOffset (rxrDataStartOffset),
        .rxrDataEndFlag     (rxrDataEndFlag),
        .rxrDataEndOffset   (rxrDataEndOffset),
        .rxrMetaFdwbe       (rxrMetaFdwbe),
        .rxrMetaLdwbe       (rxrMetaLdwbe),
        .rxrMetaTc          (rxrMetaTc),
        .rxrMetaAttr        (rxrMetaAttr),
        .rxrMetaTag         (rxrMetaTag),
        .rxrMetaType        (rxrMetaType),
        .rxrMetaAddr        (rxrMetaAddr),
        .rxrMetaBarDecoded  (rxrMetaBarDecoded),
        .rxrMetaRequesterId (rxrMetaRequesterId),
        .rxrMetaLength      (rxrMetaLength),
        .rxrMetaEp          (rxrMetaEp)
    );

endmodule

`default_nettype wire

// File: verification/rxrEngine_props.sv
`timescale 1ns/1ps
`default_nettype none

module rxrEngineProps
    import rxrPkg::*;
(
    input logic       CLK,
    input logic       arstN,
    input logic       rxrDataValid,
    input logic       rxrDataStartFlag,
    input wordEnableT rxrDataWordEnable,
    input dwOffsetT   rxrDataStartOffset,
    input reqHdrU     inHdr
);

    // Number of assertion failures so far
    int failCount = 0;

    enablesIdle: assert property (@(posedge CLK) disable iff (!arstN)
        !rxrDataValid |-> rxrDataWordEnable == '0)
        else begin
            failCount++;
            $error("word enables set while output valid is low");
        end

    startNeedsValid: assert property (@(posedge CLK) disable iff (!arstN)
        rxrDataStartFlag |-> rxrDataValid)
        else begin
            failCount++;
            $error("start flag raised without valid");
        end

    // Offset 3 traces back to a 3DW header beat on the input three edges earlier
    offset3Is3Dw: assert property (@(posedge CLK) disable iff (!arstN)
        (rxrDataValid && rxrDataStartFlag && rxrDataStartOffset == 2'd3) |->
            !$past(inHdr.h3.dw0.fmt[fmt4DwBitC], 3))
        else begin
            failCount++;
            $error("start offset 3 on a 4DW request");
        end

endmodule

bind rxrEngine rxrEngineProps uProps (
    .CLK                (CLK),
    .arstN              (arstN),
    .rxrDataValid       (rxrDataValid),
    .rxrDataStartFlag   (rxrDataStartFlag),
    .rxrDataWordEnable  (rxrDataWordEnable),
    .rxrDataStartOffset (rxrDataStartOffset),
    .inHdr              (rxTlp)
);

`default_nettype wire

// File: verification/rxrEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

module rxrEngineTb
    import rxrPkg::*;
();

    // PCIe format and type codes for stimulus
    localparam logic [2:0] fmtRd3C  = 3'b000;
    localparam logic [2:0] fmtRd4C  = 3'b001;
    localparam logic [2:0] fmtWr3C  = 3'b010;
    localparam logic [2:0] fmtWr4C  = 3'b011;
    localparam logic [4:0] cplTypeC = 5'b01010;

    typedef struct packed {
        logic [dataWidthC-1:0] data;
        wordEnableT            wordEnable;
        logic                  startFlag;
        dwOffsetT              startOffset;
        logic                  endFlag;
        dwOffsetT              endOffset;
        addrT                  addr;
        rxrTypeT               reqType;
        reqHdrU                hdr;
        barDecodeT             bar;
        int unsigned           cycle;
    } expT;

    logic                  CLK;
    logic                  arstN;
    logic [dataWidthC-1:0] rxTlp;
    logic                  rxTlpValid, rxTlpStartFlag, rxTlpEndFlag;
    dwOffsetT              rxTlpEndOffset;
    barDecodeT             rxTlpBarDecode;
    logic [dataWidthC-1:0] rxrData;
    logic                  rxrDataValid, rxrDataStartFlag, rxrDataEndFlag, rxrMetaEp;
    wordEnableT            rxrDataWordEnable;
    dwOffsetT              rxrDataStartOffset, rxrDataEndOffset;
    logic [3:0]            rxrMetaFdwbe, rxrMetaLdwbe;
    logic [2:0]            rxrMetaTc;
    logic [1:0]            rxrMetaAttr;
    logic [7:0]            rxrMetaTag;
    rxrTypeT               rxrMetaType;
    addrT                  rxrMetaAddr;
    barDecodeT             rxrMetaBarDecoded;
    logic [15:0]           rxrMetaRequesterId;
    logic [9:0]            rxrMetaLength;

    expT         expQ[$];
    int unsigned cycleCount = 0;
    int          errCount = 0;
    int          errMark = 0;
    int          checkCount = 0;
    int          testNum = 0;
    bit          hung = 1'b0;

    rxrEngine uut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
    end

    // Expected output of one input beat, straight from the request rules
    function automatic expT refBeat(input reqHdrU hdr, input int idx, input int nBeats,
                                    input dwOffsetT endOff, input barDecodeT bar,
                                    input logic [dataWidthC-1:0] data, output bit emit);
        expT e;
        bit  is4Dw;
        bit  hasPay;
        bit  first;
        bit  last;
        is4Dw  = hdr.h3.dw0.fmt[fmt4DwBitC];
        hasPay = hdr.h3.dw0.fmt[fmtPayloadBitC];
        emit   = hdr.h3.dw0.tlpType == memTypeC && !(is4Dw && hasPay && idx == 0);
        first  = (is4Dw && hasPay) ? idx == 1 : idx == 0;
        last   = idx == nBeats - 1;
        e.data        = data;
        e.startFlag   = first;
        e.startOffset = is4Dw ? 2'd0 : 2'd3;
        e.endFlag     = last;
        e.endOffset   = endOff;
        for (int dw = 0; dw < dwPerBeatC; dw++) begin
            e.wordEnable[dw] = hasPay && (!first || dw >= int'(e.startOffset))
                               && (!last || dw <= int'(endOff));
        end
        e.addr    = is4Dw ? {hdr.h4.addrHi, hdr.h4.addrLo} : {32'h0, hdr.h3.addr};
        e.reqType = hasPay ? rxrMemWr : rxrMemRd;
        e.hdr     = hdr;
        e.bar     = bar;
        e.cycle   = 0;
        return e;
    endfunction

    function automatic reqHdrU makeHdr(input logic [2:0] fmt, input logic [4:0] tlpType,
                                       input logic [9:0] len, input addrT addr);
        reqHdrU h;
        // Random tag, requester, byte enables, tc, attr and ep
        h = {$urandom, $urandom, $urandom, $urandom};
        h.h4.dw0.fmt     = fmt;
        h.h4.dw0.tlpType = tlpType;
        h.h4.dw0.length  = len;
        if (fmt[fmt4DwBitC]) begin
            h.h4.addrHi = addr[63:32];
            h.h4.addrLo = addr[31:0];
        end else begin
            h.h3.addr = addr[31:0];
        end
        return h;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            rxTlpValid     <= 1'b0;
            rxTlpStartFlag <= 1'b0;
            rxTlpEndFlag   <= 1'b0;
            rxTlp          <= {$urandom, $urandom, $urandom, $urandom};
        end
    endtask

    task automatic sendPacket(input reqHdrU hdr, input int nBeats, input dwOffsetT endOff,
                              input barDecodeT bar, input int gap);
        expT                   e;
        bit                    emit;
        logic [dataWidthC-1:0] beatData;
        for (int i = 0; i < nBeats; i++) begin
            beatData = {$urandom, $urandom, $urandom, $urandom};
            // 3DW header leaves DW3 of the first beat to payload
            if (i == 0 && hdr.h3.dw0.fmt[fmt4DwBitC]) beatData = hdr;
            if (i == 0 && !hdr.h3.dw0.fmt[fmt4DwBitC]) beatData[95:0] = hdr[95:0];
            @(posedge CLK);
            rxTlp          <= beatData;
            rxTlpValid     <= 1'b1;
            rxTlpStartFlag <= i == 0;
            rxTlpEndFlag   <= i == nBeats - 1;
            rxTlpEndOffset <= (i == nBeats - 1) ? endOff : dwOffsetT'($urandom);
            rxTlpBarDecode <= bar;
            e = refBeat(hdr, i, nBeats, endOff, bar, beatData, emit);
            // Output appears three edges later, cycleCount has not counted this edge yet
            e.cycle = cycleCount + 4;
            if (emit) expQ.push_back(e);
        end
        idle(gap);
    endtask

    task automatic sendRandomReq();
        logic [2:0] fmt;
        int         nBeats;
        dwOffsetT   endOff;
        fmt    = 3'($urandom % 4);
        endOff = dwOffsetT'($urandom);
        nBeats = 1;
        if (fmt == fmtRd3C) endOff = 2'd2;
        if (fmt == fmtRd4C) endOff = 2'd3;
        if (fmt[fmtPayloadBitC]) nBeats = 1 + int'(fmt[fmt4DwBitC]) + int'($urandom % 3);
        if (fmt == fmtWr3C && nBeats == 1) endOff = 2'd3;
        sendPacket(makeHdr(fmt, memTypeC, 10'($urandom), {$urandom, $urandom}),
                   nBeats, endOff, barDecodeT'($urandom), int'($urandom % 3));
    endtask

    task automatic checkBeat(input logic [dataWidthC-1:0] data, input wordEnableT we,
                             input logic sf, input dwOffsetT so,
                             input logic ef, input dwOffsetT eo);
        checkCount++;
        if (rxrData !== data || rxrDataWordEnable !== we || rxrDataStartFlag !== sf
            || rxrDataEndFlag !== ef || (sf && rxrDataStartOffset !== so)
            || (ef && rxrDataEndOffset !== eo)) begin
            errCount++;
            $display("ERROR %0t: beat we=%h sf=%b so=%0d ef=%b eo=%0d data=%h", $time,
                     rxrDataWordEnable, rxrDataStartFlag, rxrDataStartOffset,
                     rxrDataEndFlag, rxrDataEndOffset, rxrData);
            $display("  expected we=%h sf=%b so=%0d ef=%b eo=%0d data=%h",
                     we, sf, so, ef, eo, data);
        end
    endtask

    task automatic checkMeta(input logic [3:0] fdwbe, input logic [3:0] ldwbe,
                             input logic [2:0] tc, input logic [1:0] attr,
                             input logic [7:0] tag, input rxrTypeT reqType, input addrT addr,
                             input barDecodeT bar, input logic [15:0] rid,
                             input logic [9:0] len, input logic ep);
        checkCount++;
        if (rxrMetaFdwbe !== fdwbe || rxrMetaLdwbe !== ldwbe || rxrMetaTc !== tc
            || rxrMetaAttr !== attr || rxrMetaTag !== tag || rxrMetaType !== reqType
            || rxrMetaAddr !== addr || rxrMetaBarDecoded !== bar
            || rxrMetaRequesterId !== rid || rxrMetaLength !== len || rxrMetaEp !== ep) begin
            errCount++;
            $display("ERROR %0t: metadata tag %h/%h rid %h/%h type %0d/%0d addr %h/%h",
                     $time, rxrMetaTag, tag, rxrMetaRequesterId, rid, rxrMetaType, reqType,
                     rxrMetaAddr, addr);
        end
    endtask

    // Compare at the falling edge where outputs are settled
    always @(negedge CLK) begin
        expT e;
        while (expQ.size() > 0 && expQ[0].cycle < cycleCount) begin
            e = expQ.pop_front();
            errCount++;
            $display("ERROR %0t: output beat due in cycle %0d never appeared", $time, e.cycle);
        end
        if (rxrDataValid === 1'b1) begin
            if (expQ.size() == 0 || expQ[0].cycle != cycleCount) begin
                errCount++;
                $display("ERROR %0t: unexpected output beat", $time);
            end else begin
                e = expQ.pop_front();
                checkBeat(e.data, e.wordEnable, e.startFlag, e.startOffset,
                          e.endFlag, e.endOffset);
                checkMeta(e.hdr.h3.dw1.firstBe, e.hdr.h3.dw1.lastBe, e.hdr.h3.dw0.tc,
                          e.hdr.h3.dw0.attr, e.hdr.h3.dw1.tag, e.reqType, e.addr, e.bar,
                          e.hdr.h3.dw1.requesterId, e.hdr.h3.dw0.length, e.hdr.h3.dw0.ep);
            end
        end else begin
            checkCount++;
            if (rxrDataValid !== 1'b0 || rxrDataStartFlag !== 1'b0
                || rxrDataEndFlag !== 1'b0) begin
                errCount++;
                $display("ERROR %0t: valid or flags not low on an idle cycle", $time);
            end
        end
    end

    task automatic finishTest(input string name);
        int waited;
        idle(4);
        waited = 0;
        while (expQ.size() != 0 && waited < 50) begin
            @(posedge CLK);
            waited++;
        end
        if (expQ.size() != 0) begin
            hung = 1'b1;
            $display("Timeout: %0d expected beats never came out", expQ.size());
        end
        testNum++;
        $display("Test %0d %s: %s", testNum, name,
                 (errCount == errMark && !hung) ? "passed" : "failed");
        errMark = errCount;
    endtask

    initial begin
        void'($urandom(74055));
        arstN          = 1'b0;
        rxTlp          = '0;
        rxTlpValid     = 1'b0;
        rxTlpStartFlag = 1'b0;
        rxTlpEndFlag   = 1'b0;
        rxTlpEndOffset = '0;
        rxTlpBarDecode = '0;
        repeat (10) @(posedge CLK);
        arstN <= 1'b1;
        idle(20);
        finishTest("reset and idle");

        sendPacket(makeHdr(fmtWr3C, memTypeC, 10'd1, addrT'($urandom)), 1, 2'd3, 8'h01, 2);
        finishTest("3DW single DW write");

        // Ten DWs over three data beats, last one ends at DW1
        sendPacket(makeHdr(fmtWr4C, memTypeC, 10'd10, {$urandom, $urandom}), 4, 2'd1, 8'h04, 2);
        finishTest("4DW multi-beat write");

        sendPacket(makeHdr(fmtRd3C, memTypeC, 10'd8, addrT'($urandom)), 1, 2'd2, 8'h02, 1);
        sendPacket(makeHdr(fmtRd4C, memTypeC, 10'd16, {$urandom, $urandom}), 1, 2'd3, 8'h20, 1);
        finishTest("3DW and 4DW reads");

        for (int k = 0; k < 12; k++) begin
            if ($urandom % 2) begin
                sendPacket(makeHdr(fmtWr3C, cplTypeC, 10'd4, '0), 2, 2'd2, '0,
                           int'($urandom % 3));
            end
            sendRandomReq();
        end
        finishTest("completions between requests");

        errCount += uut.uProps.failCount;
        $display("Tests: %0d, checks: %0d, errors: %0d", testNum, checkCount, errCount);
        if (errCount == 0 && !hung) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/rxrPkg.sv
source/rxrBeatIf.sv
source/rxrMetaIf.sv
source/rxrHdrCapture.sv
source/rxrReqDecode.sv
source/rxrOutputStage.sv
source/rxrEngine.sv
verification/rxrEngine_props.sv
verification/rxrEngineTb.sv

// File: Makefile
# Verilator simulation of the PCIe receive request engine

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module rxrEngineTb \
		-f filelist.f -Mdir obj_dir
	./obj_dir/VrxrEngineTb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
